//--- logic/upi_pkg.sv
// Widths, opcodes and sequencer states for the UPI slave controller
// Opcodes are a subset of MCS-48, undefined values run as NOP
package upi_pkg;

    // Data byte for A, host bus and ports
    typedef logic [7:0]  data_t;
    // Program address, sized for a 2 KB ROM
    typedef logic [10:0] pc_t;
    // Data RAM address, 64 bytes
    typedef logic [5:0]  ram_addr_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        OPERAND,
        EXEC,
        RAM_RD,
        WRITEBACK
    } seq_state_t;

    // One-byte instructions
    localparam data_t OP_NOP      = 8'h00;
    localparam data_t OP_INC_A    = 8'h17;
    localparam data_t OP_CLR_A    = 8'h27;
    localparam data_t OP_IN_DBB   = 8'h22;
    localparam data_t OP_OUT_DBB  = 8'h02;
    localparam data_t OP_IN_P1    = 8'h09;
    localparam data_t OP_IN_P2    = 8'h0A;
    localparam data_t OP_OUTL_P1  = 8'h39;
    localparam data_t OP_OUTL_P2  = 8'h3A;

    // Register forms, low three bits select Rr
    localparam data_t OP_RR_MASK  = 8'hF8;
    localparam data_t OP_MOV_A_R  = 8'hF8;
    localparam data_t OP_MOV_R_A  = 8'hA8;
    localparam data_t OP_ADD_A_R  = 8'h68;

    // Immediate forms
    localparam data_t OP_MOV_A_I  = 8'h23;
    localparam data_t OP_ADD_A_I  = 8'h03;
    localparam data_t OP_ANL_A_I  = 8'h53;
    localparam data_t OP_ORL_A_I  = 8'h43;

    // JMP carries page bits in [7:5]
    localparam data_t OP_JMP_MASK = 8'h1F;
    localparam data_t OP_JMP      = 8'h04;

    // In-page conditional jumps
    localparam data_t OP_JNIBF    = 8'hD6;
    localparam data_t OP_JOBF     = 8'h86;
    localparam data_t OP_JT0      = 8'h36;
    localparam data_t OP_JNT0     = 8'h26;
    localparam data_t OP_JT1      = 8'h56;
    localparam data_t OP_JNT1     = 8'h46;
    localparam data_t OP_JZ       = 8'hC6;
    localparam data_t OP_JNZ      = 8'h96;

    // Status byte bit positions
    localparam int STAT_OBF = 0;
    localparam int STAT_IBF = 1;
    localparam int STAT_F0  = 2;
    localparam int STAT_F1  = 3;

endpackage

//--- logic/upi_ram_if.sv
// Sequencer to data RAM link, read data arrives one clk after addr
`timescale 1ns/1ns

interface upi_ram_if;

    upi_pkg::ram_addr_t addr;
    upi_pkg::data_t     wdata;
    logic               we;
    upi_pkg::data_t     rdata;

    // Sequencer side
    modport master (output addr, output wdata, output we, input rdata);

    // Memory side
    modport mem (input addr, input wdata, input we, output rdata);

endinterface

//--- logic/upi_dbb_if.sv
// Sequencer to host bus buffer link, out_we and in_ack are one-clk pulses
`timescale 1ns/1ns

interface upi_dbb_if;

    // Host buffer towards sequencer
    upi_pkg::data_t dbb_in;
    logic           ibf;
    logic           obf;

    // Sequencer towards host buffer
    upi_pkg::data_t dbb_out;
    logic           out_we;
    logic           in_ack;

    modport host (
        output dbb_in, output ibf, output obf,
        input  dbb_out, input out_we, input in_ack
    );

    modport core (
        input  dbb_in, input ibf, input obf,
        output dbb_out, output out_we, output in_ack
    );

endinterface

//--- logic/upi_seq.sv
// Fetch, decode and execute of the MCS-48 subset, one state per three cen pulses
// No carry, PSW, stack or register banks; Rr always maps to RAM 0..7
`timescale 1ns/1ns

module upi_seq #(
    parameter int ROM_AW = 11
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           cen_i,
    output upi_pkg::pc_t   rom_addr_o,
    input  upi_pkg::data_t rom_data_i,
    upi_ram_if.master      ram,
    upi_dbb_if.core        dbb,
    output logic           p1_we_o,
    output logic           p2_we_o,
    output upi_pkg::data_t port_data_o,
    input  upi_pkg::data_t p1_rd_i,
    input  upi_pkg::data_t p2_rd_i,
    input  logic           t0_i,
    input  logic           t1_i
);

    // Keeps the PC inside the fitted ROM
    localparam upi_pkg::pc_t PC_MASK = upi_pkg::pc_t'((1 << ROM_AW) - 1);

    logic [1:0]          div_cnt;
    logic                st_en;
    logic                exec_fire;
    upi_pkg::seq_state_t state;
    upi_pkg::pc_t        pc;
    upi_pkg::data_t      acc;
    upi_pkg::data_t      ir;
    upi_pkg::data_t      opnd;
    logic                need_opnd;
    logic                rr_read;
    logic                jump_take;

    // Divide cen by three
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            div_cnt <= 2'd0;
        end else if (cen_i) begin
            div_cnt <= (div_cnt == 2'd2) ? 2'd0 : div_cnt + 2'd1;
        end
    end

    assign st_en     = cen_i && (div_cnt == 2'd2);
    assign exec_fire = st_en && (state == upi_pkg::EXEC);

    // Instruction classes
    assign rr_read = ((ir & upi_pkg::OP_RR_MASK) == upi_pkg::OP_MOV_A_R) ||
                     ((ir & upi_pkg::OP_RR_MASK) == upi_pkg::OP_ADD_A_R);

    always_comb begin
        case (ir)
            upi_pkg::OP_MOV_A_I, upi_pkg::OP_ADD_A_I,
            upi_pkg::OP_ANL_A_I, upi_pkg::OP_ORL_A_I,
            upi_pkg::OP_JNIBF,   upi_pkg::OP_JOBF,
            upi_pkg::OP_JT0,     upi_pkg::OP_JNT0,
            upi_pkg::OP_JT1,     upi_pkg::OP_JNT1,
            upi_pkg::OP_JZ,      upi_pkg::OP_JNZ: need_opnd = 1'b1;
            default: need_opnd = ((ir & upi_pkg::OP_JMP_MASK) == upi_pkg::OP_JMP);
        endcase
    end

    // Conditional jump tests
    always_comb begin
        case (ir)
            upi_pkg::OP_JNIBF: jump_take = !dbb.ibf;
            upi_pkg::OP_JOBF:  jump_take = dbb.obf;
            upi_pkg::OP_JT0:   jump_take = t0_i;
            upi_pkg::OP_JNT0:  jump_take = !t0_i;
            upi_pkg::OP_JT1:   jump_take = t1_i;
            upi_pkg::OP_JNT1:  jump_take = !t1_i;
            upi_pkg::OP_JZ:    jump_take = (acc == 8'h00);
            upi_pkg::OP_JNZ:   jump_take = (acc != 8'h00);
            default:           jump_take = 1'b0;
        endcase
    end

    // Main state machine
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= upi_pkg::FETCH;
            pc    <= '0;
            acc   <= 8'h00;
            ir    <= upi_pkg::OP_NOP;
        end else if (st_en) begin
            case (state)
                upi_pkg::FETCH: begin
                    // ROM data already reflects pc
                    ir    <= rom_data_i;
                    pc    <= (pc + 1'b1) & PC_MASK;
                    state <= upi_pkg::DECODE;
                end
                upi_pkg::DECODE: begin
                    if (need_opnd) begin
                        state <= upi_pkg::OPERAND;
                    end else if (rr_read) begin
                        state <= upi_pkg::RAM_RD;
                    end else begin
                        state <= upi_pkg::EXEC;
                    end
                end
                upi_pkg::OPERAND: begin
                    opnd  <= rom_data_i;
                    pc    <= (pc + 1'b1) & PC_MASK;
                    state <= upi_pkg::EXEC;
                end
                upi_pkg::RAM_RD: begin
                    // Address was set from ir during DECODE
                    state <= upi_pkg::WRITEBACK;
                end
                upi_pkg::WRITEBACK: begin
                    if ((ir & upi_pkg::OP_RR_MASK) == upi_pkg::OP_ADD_A_R) begin
                        acc <= acc + ram.rdata;
                    end else begin
                        acc <= ram.rdata;
                    end
                    state <= upi_pkg::FETCH;
                end
                upi_pkg::EXEC: begin
                    if ((ir & upi_pkg::OP_JMP_MASK) == upi_pkg::OP_JMP) begin
                        // Page bits come from the opcode
                        pc <= upi_pkg::pc_t'({ir[7:5], opnd}) & PC_MASK;
                    end else begin
                        case (ir)
                            upi_pkg::OP_MOV_A_I: acc <= opnd;
                            upi_pkg::OP_ADD_A_I: acc <= acc + opnd;
                            upi_pkg::OP_ANL_A_I: acc <= acc & opnd;
                            upi_pkg::OP_ORL_A_I: acc <= acc | opnd;
                            upi_pkg::OP_INC_A:   acc <= acc + 8'd1;
                            upi_pkg::OP_CLR_A:   acc <= 8'h00;
                            upi_pkg::OP_IN_DBB:  acc <= dbb.dbb_in;
                            upi_pkg::OP_IN_P1:   acc <= p1_rd_i;
                            upi_pkg::OP_IN_P2:   acc <= p2_rd_i;
                            default: begin
                                // In-page jump keeps the current page
                                if (jump_take) begin
                                    pc <= {pc[10:8], opnd} & PC_MASK;
                                end
                            end
                        endcase
                    end
                    state <= upi_pkg::FETCH;
                end
                default: state <= upi_pkg::FETCH;
            endcase
        end
    end

    assign rom_addr_o = pc;

    // Rr accesses
    assign ram.addr  = {3'b000, ir[2:0]};
    assign ram.wdata = acc;
    assign ram.we    = exec_fire &&
                       ((ir & upi_pkg::OP_RR_MASK) == upi_pkg::OP_MOV_R_A);

    // Host buffer strobes
    assign dbb.dbb_out = acc;
    assign dbb.out_we  = exec_fire && (ir == upi_pkg::OP_OUT_DBB);
    assign dbb.in_ack  = exec_fire && (ir == upi_pkg::OP_IN_DBB);

    // Port latch strobes
    assign port_data_o = acc;
    assign p1_we_o     = exec_fire && (ir == upi_pkg::OP_OUTL_P1);
    assign p2_we_o     = exec_fire && (ir == upi_pkg::OP_OUTL_P2);

endmodule

//--- logic/upi_host_bus.sv
// Host data bus buffer, strobes must be synchronous to clk
// No back-pressure, a write with IBF set overwrites DBBIN
`timescale 1ns/1ns

module upi_host_bus (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           a0_i,
    input  logic           cs_n_i,
    input  logic           rd_n_i,
    input  logic           wr_n_i,
    input  upi_pkg::data_t din_i,
    output upi_pkg::data_t dout_o,
    upi_dbb_if.host        dbb
);

    logic           wr_n_q;
    logic           rd_n_q;
    logic           wr_rise;
    logic           rd_rise;
    logic           ibf;
    logic           obf;
    logic           f1;
    upi_pkg::data_t dbbin;
    upi_pkg::data_t dbbout;
    upi_pkg::data_t status;

    // Strobe edge detect
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_n_q <= 1'b1;
            rd_n_q <= 1'b1;
        end else begin
            wr_n_q <= wr_n_i;
            rd_n_q <= rd_n_i;
        end
    end

    assign wr_rise = wr_n_i && !wr_n_q && !cs_n_i;
    assign rd_rise = rd_n_i && !rd_n_q && !cs_n_i;

    // Flags, set wins over clear
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ibf <= 1'b0;
            obf <= 1'b0;
            f1  <= 1'b0;
        end else begin
            if (wr_rise) begin
                ibf <= 1'b1;
                f1  <= a0_i;
            end else if (dbb.in_ack) begin
                ibf <= 1'b0;
            end
            if (dbb.out_we) begin
                obf <= 1'b1;
            end else if (rd_rise && !a0_i) begin
                obf <= 1'b0;
            end
        end
    end

    // Data registers
    always_ff @(posedge clk) begin
        if (wr_rise) begin
            dbbin <= din_i;
        end
        if (dbb.out_we) begin
            dbbout <= dbb.dbb_out;
        end
    end

    always_comb begin
        status                   = 8'h00;
        status[upi_pkg::STAT_OBF] = obf;
        status[upi_pkg::STAT_IBF] = ibf;
        // F0 stays low, nothing sets it
        status[upi_pkg::STAT_F0]  = 1'b0;
        status[upi_pkg::STAT_F1]  = f1;
    end

    // Read mux, A0 high selects status
    assign dout_o = (!cs_n_i && !rd_n_i) ? (a0_i ? status : dbbout) : 8'h00;

    assign dbb.dbb_in = dbbin;
    assign dbb.ibf    = ibf;
    assign dbb.obf    = obf;

endmodule

//--- logic/upi_prog_rom.sv
// Loadable program memory, read data one clk after address
// Clears to NOP at start, load while the core is in reset
`timescale 1ns/1ns

module upi_prog_rom #(
    parameter int ROM_AW = 11
) (
    input  logic              clk,
    input  logic [ROM_AW-1:0] rd_addr_i,
    output upi_pkg::data_t    rd_data_o,
    input  logic [ROM_AW-1:0] wr_addr_i,
    input  upi_pkg::data_t    wr_data_i,
    input  logic              we_i
);

    upi_pkg::data_t mem [2**ROM_AW];

    // Empty ROM runs NOPs
    initial begin
        for (int i = 0; i < 2**ROM_AW; i++) begin
            mem[i] = upi_pkg::OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- logic/upi_data_ram.sv
// 64 byte data RAM, R0..R7 sit at the bottom
`timescale 1ns/1ns

module upi_data_ram (
    input  logic    clk,
    upi_ram_if.mem  ram
);

    upi_pkg::data_t mem [64];

    // Write-first, new data shows on the same read
    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
            ram.rdata     <= ram.wdata;
        end else begin
            ram.rdata <= mem[ram.addr];
        end
    end

endmodule

//--- logic/upi_ports.sv
// Quasi-bidirectional P1/P2, pin reads are ANDed with the latch
// T0 and T1 pass through two flops before the sequencer sees them
`timescale 1ns/1ns

module upi_ports (
    input  logic           clk,
    input  logic           rst_n_i,
    input  upi_pkg::data_t p1_din_i,
    input  upi_pkg::data_t p2_din_i,
    output upi_pkg::data_t p1_dout_o,
    output upi_pkg::data_t p2_dout_o,
    input  logic           p1_we_i,
    input  logic           p2_we_i,
    input  upi_pkg::data_t port_data_i,
    output upi_pkg::data_t p1_rd_o,
    output upi_pkg::data_t p2_rd_o,
    input  logic           t0_din_i,
    input  logic           t1_din_i,
    output logic           t0_o,
    output logic           t1_o
);

    upi_pkg::data_t p1_lat;
    upi_pkg::data_t p2_lat;
    logic [1:0]     t0_sync;
    logic [1:0]     t1_sync;

    // Latches come up high, pins act as inputs
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            p1_lat <= 8'hFF;
            p2_lat <= 8'hFF;
        end else begin
            if (p1_we_i) begin
                p1_lat <= port_data_i;
            end
            if (p2_we_i) begin
                p2_lat <= port_data_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t0_sync <= 2'b00;
            t1_sync <= 2'b00;
        end else begin
            t0_sync <= {t0_sync[0], t0_din_i};
            t1_sync <= {t1_sync[0], t1_din_i};
        end
    end

    assign p1_dout_o = p1_lat;
    assign p2_dout_o = p2_lat;
    // Low latch bit pulls the pin low
    assign p1_rd_o   = p1_din_i & p1_lat;
    assign p2_rd_o   = p2_din_i & p2_lat;
    assign t0_o      = t0_sync[1];
    assign t1_o      = t1_sync[1];

endmodule

//--- logic/upi_top.sv
// UPI-style slave controller, host strobes synchronous to clk
// Load the program through prom_we while rst_n_i is low
`timescale 1ns/1ns

module upi_top #(
    parameter int ROM_AW = 11
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           cen_i,
    input  logic           a0_i,
    input  logic           cs_n_i,
    input  logic           rd_n_i,
    input  logic           wr_n_i,
    input  upi_pkg::data_t din_i,
    output upi_pkg::data_t dout_o,
    input  upi_pkg::data_t p1_din_i,
    input  upi_pkg::data_t p2_din_i,
    output upi_pkg::data_t p1_dout_o,
    output upi_pkg::data_t p2_dout_o,
    input  logic           t0_din_i,
    input  logic           t1_din_i,
    input  upi_pkg::pc_t   prog_addr_i,
    input  upi_pkg::data_t prog_data_i,
    input  logic           prom_we_i
);

    upi_pkg::pc_t   rom_addr;
    upi_pkg::data_t rom_data;
    upi_pkg::data_t port_data;
    upi_pkg::data_t p1_rd;
    upi_pkg::data_t p2_rd;
    logic           p1_we;
    logic           p2_we;
    logic           t0;
    logic           t1;

    upi_ram_if ram_if ();
    upi_dbb_if dbb_if ();

    upi_seq #(.ROM_AW(ROM_AW)) u_seq (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cen_i       (cen_i),
        .rom_addr_o  (rom_addr),
        .rom_data_i  (rom_data),
        .ram         (ram_if.master),
        .dbb         (dbb_if.core),
        .p1_we_o     (p1_we),
        .p2_we_o     (p2_we),
        .port_data_o (port_data),
        .p1_rd_i     (p1_rd),
        .p2_rd_i     (p2_rd),
        .t0_i        (t0),
        .t1_i        (t1)
    );

    upi_host_bus u_host_bus (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .a0_i    (a0_i),
        .cs_n_i  (cs_n_i),
        .rd_n_i  (rd_n_i),
        .wr_n_i  (wr_n_i),
        .din_i   (din_i),
        .dout_o  (dout_o),
        .dbb     (dbb_if.host)
    );

    // Only the low ROM_AW address bits reach the memory
    upi_prog_rom #(.ROM_AW(ROM_AW)) u_prog_rom (
        .clk       (clk),
        .rd_addr_i (rom_addr[ROM_AW-1:0]),
        .rd_data_o (rom_data),
        .wr_addr_i (prog_addr_i[ROM_AW-1:0]),
        .wr_data_i (prog_data_i),
        .we_i      (prom_we_i)
    );

    upi_data_ram u_data_ram (
        .clk (clk),
        .ram (ram_if.mem)
    );

    upi_ports u_ports (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .p1_din_i    (p1_din_i),
        .p2_din_i    (p2_din_i),
        .p1_dout_o   (p1_dout_o),
        .p2_dout_o   (p2_dout_o),
        .p1_we_i     (p1_we),
        .p2_we_i     (p2_we),
        .port_data_i (port_data),
        .p1_rd_o     (p1_rd),
        .p2_rd_o     (p2_rd),
        .t0_din_i    (t0_din_i),
        .t1_din_i    (t1_din_i),
        .t0_o        (t0),
        .t1_o        (t1)
    );

endmodule

//--- verification/upi_asserts.sv
// Sequencer strobe and state stepping checks bound into upi_seq
// Needs assertion support switched on in the simulator
`timescale 1ns/1ns

module upi_asserts (
    input logic                clk,
    input logic                rst_n_i,
    input logic                st_en_i,
    input upi_pkg::seq_state_t state_i,
    input logic                out_we_i,
    input logic                in_ack_i,
    input logic                ram_we_i,
    input logic                p1_we_i,
    input logic                p2_we_i
);

    logic any_strobe;

    assign any_strobe = out_we_i || in_ack_i || ram_we_i || p1_we_i || p2_we_i;

    // OUT DBB and IN DBB never decode in the same EXEC
    a_dbb_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(out_we_i && in_ack_i))
        else $error("out_we and in_ack pulsed in the same cycle");

    // Divider and state are cleared after one reset cycle so no EXEC can fire
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n_i && $past(!rst_n_i)) |-> !any_strobe)
        else $error("strobe pulse seen while reset held");

    // State moves only on the divided enable
    a_state_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        !st_en_i |=> $stable(state_i))
        else $error("sequencer state changed without divided enable");

endmodule

//--- verification/upi_tb.sv
// Host-side testbench for upi_top, program loaded through prom_we under reset
// Expects P1 latch to stay at FF, the program never writes P1
`timescale 1ns/1ns

module upi_tb;

    localparam int MAX_TXN        = 40;
    localparam int CYCLES_PER_TXN = 200;
    localparam int TIMEOUT_CYCLES = MAX_TXN * CYCLES_PER_TXN;
    localparam int PROG_LEN       = 20;

    logic           clk;
    logic           rst_n_i;
    logic           cen_i;
    logic           a0_i;
    logic           cs_n_i;
    logic           rd_n_i;
    logic           wr_n_i;
    upi_pkg::data_t din_i;
    upi_pkg::data_t dout_o;
    upi_pkg::data_t p1_din_i;
    upi_pkg::data_t p2_din_i;
    upi_pkg::data_t p1_dout_o;
    upi_pkg::data_t p2_dout_o;
    logic           t0_din_i;
    logic           t1_din_i;
    upi_pkg::pc_t   prog_addr_i;
    upi_pkg::data_t prog_data_i;
    logic           prom_we_i;

    // Pending checks, filled by stimulus and drained by the compare process
    upi_pkg::data_t got_q [$];
    upi_pkg::data_t exp_q [$];
    string          what_q [$];

    int     n_checks  = 0;
    int     n_errors  = 0;
    int     cycle_cnt = 0;
    integer seed      = 89;

    upi_pkg::data_t prog_image [PROG_LEN];

    upi_top #(.ROM_AW(11)) i_upi_top (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cen_i       (cen_i),
        .a0_i        (a0_i),
        .cs_n_i      (cs_n_i),
        .rd_n_i      (rd_n_i),
        .wr_n_i      (wr_n_i),
        .din_i       (din_i),
        .dout_o      (dout_o),
        .p1_din_i    (p1_din_i),
        .p2_din_i    (p2_din_i),
        .p1_dout_o   (p1_dout_o),
        .p2_dout_o   (p2_dout_o),
        .t0_din_i    (t0_din_i),
        .t1_din_i    (t1_din_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .prom_we_i   (prom_we_i)
    );

    bind upi_seq upi_asserts u_asserts (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .st_en_i  (st_en),
        .state_i  (state),
        .out_we_i (dbb.out_we),
        .in_ack_i (dbb.in_ack),
        .ram_we_i (ram.we),
        .p1_we_i  (p1_we_o),
        .p2_we_i  (p2_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // IN P1 sees pin AND latch, latch is FF; R3 holds the host byte
    function automatic upi_pkg::data_t expected_result(
        input upi_pkg::data_t x,
        input upi_pkg::data_t p1_pin,
        input logic           t0
    );
        upi_pkg::data_t acc;
        acc = (p1_pin & 8'hFF) + x;
        acc = acc + 8'h5A;
        return t0 ? (acc | 8'h80) : (acc & 8'h7F);
    endfunction

    task automatic check_eq(
        input upi_pkg::data_t got,
        input upi_pkg::data_t exp,
        input string          what
    );
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL at %0t ns: %s, got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic queue_check(
        input upi_pkg::data_t got,
        input upi_pkg::data_t exp,
        input string          what
    );
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    // Queues are filled off the rising edge, drained on it
    always @(posedge clk) begin
        while (got_q.size() != 0) begin
            check_eq(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // wr_n low for two cycles, rises while cs_n is still low
    task automatic host_write(input logic a0, input upi_pkg::data_t value);
        next_cycle();
        cs_n_i = 1'b0;
        a0_i   = a0;
        din_i  = value;
        wr_n_i = 1'b0;
        next_cycle();
        next_cycle();
        wr_n_i = 1'b1;
        next_cycle();
        cs_n_i = 1'b1;
        a0_i   = 1'b0;
    endtask

    task automatic host_read(input logic a0, output upi_pkg::data_t value);
        next_cycle();
        cs_n_i = 1'b0;
        a0_i   = a0;
        rd_n_i = 1'b0;
        // dout is combinational, settled by mid cycle
        @(negedge clk);
        value = dout_o;
        next_cycle();
        rd_n_i = 1'b1;
        next_cycle();
        cs_n_i = 1'b1;
        a0_i   = 1'b0;
    endtask

    task automatic poll_status(input int bit_idx);
        upi_pkg::data_t st;
        host_read(1'b1, st);
        while (!st[bit_idx]) begin
            host_read(1'b1, st);
        end
    endtask

    task automatic load_program();
        prog_image = '{
            upi_pkg::OP_JNIBF,         8'h00,
            upi_pkg::OP_IN_DBB,
            upi_pkg::OP_MOV_R_A | 8'h03,
            upi_pkg::OP_IN_P1,
            upi_pkg::OP_ADD_A_R | 8'h03,
            upi_pkg::OP_ADD_A_I,       8'h5A,
            upi_pkg::OP_JT0,           8'h0E,
            upi_pkg::OP_ANL_A_I,       8'h7F,
            upi_pkg::OP_JMP,           8'h10,
            upi_pkg::OP_ORL_A_I,       8'h80,
            upi_pkg::OP_OUTL_P2,
            upi_pkg::OP_OUT_DBB,
            upi_pkg::OP_JMP,           8'h00
        };
        for (int i = 0; i < PROG_LEN; i++) begin
            next_cycle();
            prom_we_i   = 1'b1;
            prog_addr_i = upi_pkg::pc_t'(i);
            prog_data_i = prog_image[i];
        end
        next_cycle();
        prom_we_i = 1'b0;
    endtask

    // One host byte through the program, result read back by polling OBF
    task automatic run_txn(
        input logic           a0,
        input upi_pkg::data_t x,
        input upi_pkg::data_t p1_pin,
        input logic           t0,
        input int             idx
    );
        upi_pkg::data_t exp_res;
        upi_pkg::data_t st;
        upi_pkg::data_t res;
        exp_res = expected_result(x, p1_pin, t0);
        next_cycle();
        p1_din_i = p1_pin;
        t0_din_i = t0;
        host_write(a0, x);
        host_read(1'b1, st);
        // IBF set, F1 follows a0, OBF still low
        queue_check(st & 8'h0F, {4'h0, a0, 3'b010}, $sformatf("txn %0d status after write", idx));
        poll_status(upi_pkg::STAT_OBF);
        host_read(1'b0, res);
        queue_check(res, exp_res, $sformatf("txn %0d DBB result", idx));
        @(negedge clk);
        queue_check(p2_dout_o, exp_res, $sformatf("txn %0d P2 latch", idx));
        host_read(1'b1, st);
        queue_check(st & 8'h0F, {4'h0, a0, 3'b000}, $sformatf("txn %0d status after read", idx));
    endtask

    initial begin
        int             rnd;
        int             txn;
        upi_pkg::data_t x;
        upi_pkg::data_t p1_pin;
        upi_pkg::data_t st;
        logic           t0;

        rst_n_i     = 1'b0;
        cen_i       = 1'b1;
        a0_i        = 1'b0;
        cs_n_i      = 1'b1;
        rd_n_i      = 1'b1;
        wr_n_i      = 1'b1;
        din_i       = 8'h00;
        p1_din_i    = 8'hFF;
        p2_din_i    = 8'hFF;
        t0_din_i    = 1'b0;
        t1_din_i    = 1'b0;
        prog_addr_i = '0;
        prog_data_i = 8'h00;
        prom_we_i   = 1'b0;
        txn         = 0;
        t0          = 1'b0;

        // Load under reset, then eight more reset cycles
        load_program();
        repeat (8) next_cycle();
        rst_n_i = 1'b1;

        // Reset state of flags and port latches
        host_read(1'b1, st);
        queue_check(st, 8'h00, "status after reset");
        queue_check(p1_dout_o, 8'hFF, "P1 latch after reset");
        queue_check(p2_dout_o, 8'hFF, "P2 latch after reset");

        // Data write, then command write with F1 set
        run_txn(1'b0, 8'h3C, 8'hFF, 1'b0, txn++);
        run_txn(1'b1, 8'hA5, 8'h0F, 1'b1, txn++);

        t0 = 1'b0;
        for (int i = 0; i < 30; i++) begin
            rnd    = $random(seed);
            x      = rnd[7:0];
            p1_pin = rnd[15:8];
            run_txn(1'b0, x, p1_pin, t0, txn++);
        end

        // T0 flips between transactions
        for (int i = 0; i < 4; i++) begin
            t0     = ~t0;
            rnd    = $random(seed);
            x      = rnd[7:0];
            p1_pin = rnd[15:8];
            run_txn(1'b0, x, p1_pin, t0, txn++);
        end

        queue_check(p1_dout_o, 8'hFF, "P1 latch at end");
        repeat (2) @(posedge clk);

        $display("Transactions: %0d, checks: %0d, errors: %0d", txn, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- upi_top.f
logic/upi_pkg.sv
logic/upi_ram_if.sv
logic/upi_dbb_if.sv
logic/upi_seq.sv
logic/upi_host_bus.sv
logic/upi_prog_rom.sv
logic/upi_data_ram.sv
logic/upi_ports.sv
logic/upi_top.sv
verification/upi_asserts.sv
verification/upi_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UPI testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f upi_top.f --top-module upi_tb -o upi_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/upi_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
